//--- hdl/mipsIsaPkg.sv
// MIPS32 instruction encodings and decode types shared by the fetch front end and its decoder
package mipsIsaPkg;

    // Primary opcodes used by the front end
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opBlez    = 6'h06;
    localparam logic [5:0] opBgtz    = 6'h07;

    // SPECIAL function codes for register jumps
    localparam logic [5:0] functJr   = 6'h08;
    localparam logic [5:0] functJalr = 6'h09;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormatT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFormatT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } jFormatT;

    // One instruction word, three ways of reading it
    typedef union packed {
        rFormatT rFormat;
        iFormatT iFormat;
        jFormatT jFormat;
    } instrWord;

    // What the D-stage word means for the next PC
    typedef enum logic [2:0] {
        classOther,
        classBranch,
        classJumpImm,
        classJumpReg
    } instrClass;

    typedef enum logic [1:0] {
        condEq,
        condNe,
        condLez,
        condGtz
    } branchCond;

endpackage

//--- hdl/mipsMemPkg.sv
// Memory map defaults and exception codes for the instruction fetch front end
package mipsMemPkg;

    // First instruction after reset
    localparam logic [31:0] defaultBootAddress = 32'h0000_3000;

    // Exception handler entry point
    localparam logic [31:0] defaultExcEntry    = 32'h0000_4180;

    // Instruction memory window, both ends inclusive
    localparam logic [31:0] defaultImStart     = 32'h0000_3000;
    localparam logic [31:0] defaultImEnd       = 32'h0000_6FFC;

    // CP0 Cause.ExcCode values raised by fetch
    typedef enum logic [4:0] {
        excNone = 5'd0,
        excAdEL = 5'd4
    } excCode;

endpackage

//--- hdl/ProgramCounter.sv
// Program counter with next-PC selection, delay-slot flag and fetch address-error check
`timescale 1ns/1ps

module ProgramCounter
    import mipsIsaPkg::*;
    import mipsMemPkg::*;
#(
    parameter logic [31:0] bootAddress = defaultBootAddress,
    parameter logic [31:0] excEntry    = defaultExcEntry,
    parameter logic [31:0] imStart     = defaultImStart,
    parameter logic [31:0] imEnd       = defaultImEnd
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        en,
    input  instrClass   iClass,
    input  logic        branchTaken,
    input  logic [15:0] imm16,
    input  logic [25:0] jTarget,
    input  logic [31:0] jumpReg,
    input  logic        excEnter,
    input  logic        excReturn,
    input  logic [31:0] epc,
    output logic [31:0] pc,
    output logic        bd,
    output excCode      exc
);

    logic [31:0] nextPc;
    logic [31:0] branchAddr;
    logic [31:0] jumpAddr;
    logic        halted;

    // pc already points at the delay slot here
    assign branchAddr = pc + {{14{imm16[15]}}, imm16, 2'b00};
    assign jumpAddr   = {pc[31:28], jTarget, 2'b00};

    // Parked on the word just below the handler
    assign halted = (pc == excEntry - 32'd4);

    always_comb begin
        if (excEnter) begin
            nextPc = excEntry;
        end else if (excReturn) begin
            nextPc = {epc[31:2], 2'b00};
        end else if (halted) begin
            nextPc = pc;
        end else if (iClass == classJumpReg) begin
            nextPc = jumpReg;
        end else if (iClass == classJumpImm) begin
            nextPc = jumpAddr;
        end else if (iClass == classBranch && branchTaken) begin
            nextPc = branchAddr;
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= bootAddress;
        end else if (en) begin
            pc <= nextPc;
        end
    end

    // Any branch or jump in D makes this word its delay slot, taken or not
    assign bd = (iClass != classOther);

    assign exc = (pc < imStart || pc > imEnd || pc[1:0] != 2'b00) ? excAdEL : excNone;

    pcHeldAtBoot: assert property (@(posedge clk) reset |=> pc == bootAddress)
        else $error("PC left the boot address while reset was high");

endmodule

//--- hdl/BranchDecoder.sv
// D-stage branch and jump decoder that classifies the word and resolves the branch condition
`timescale 1ns/1ps

module BranchDecoder
    import mipsIsaPkg::*;
(
    input  logic [31:0] codeD,
    input  logic        fetchValid,
    input  logic [31:0] rsValue,
    input  logic [31:0] rtValue,
    output instrClass   iClass,
    output logic        branchTaken,
    output logic [15:0] imm16,
    output logic [25:0] jTarget,
    output logic [31:0] jumpReg,
    output logic [4:0]  rsIndex,
    output logic [4:0]  rtIndex
);

    instrWord  word;
    branchCond cond;
    logic      condMet;

    assign word = codeD;

    // Bubbles decode as ordinary instructions
    always_comb begin
        iClass = classOther;
        cond   = condEq;
        if (fetchValid) begin
            case (word.rFormat.opcode)
                opBeq: begin
                    iClass = classBranch;
                    cond   = condEq;
                end
                opBne: begin
                    iClass = classBranch;
                    cond   = condNe;
                end
                opBlez: begin
                    iClass = classBranch;
                    cond   = condLez;
                end
                opBgtz: begin
                    iClass = classBranch;
                    cond   = condGtz;
                end
                opJ, opJal: iClass = classJumpImm;
                opSpecial: begin
                    if (word.rFormat.funct == functJr || word.rFormat.funct == functJalr) begin
                        iClass = classJumpReg;
                    end
                end
                default: iClass = classOther;
            endcase
        end
    end

    // BLEZ and BGTZ look at rs alone, as signed
    always_comb begin
        case (cond)
            condEq:  condMet = (rsValue == rtValue);
            condNe:  condMet = (rsValue != rtValue);
            condLez: condMet = ($signed(rsValue) <= 32'sd0);
            default: condMet = ($signed(rsValue) > 32'sd0);
        endcase
    end

    assign branchTaken = (iClass == classBranch) && condMet;

    assign imm16   = word.iFormat.imm16;
    assign jTarget = word.jFormat.target26;
    assign jumpReg = rsValue;
    assign rsIndex = word.rFormat.rs;
    assign rtIndex = word.iFormat.rt;

endmodule

//--- hdl/FetchControl.sv
// Fetch pipeline control that merges memory wait, downstream stall and CP0 redirects
`timescale 1ns/1ps

module FetchControl (
    input  logic iReady,
    input  logic stallIn,
    input  logic excEnter,
    input  logic excReturn,
    output logic enPC,
    output logic stall,
    output logic clear,
    output logic busy
);

    logic advance;

    // A fetch completes only when memory answers and nothing downstream holds us
    assign advance = iReady && !stallIn;

    assign enPC  = advance;
    assign stall = !advance;

    // Redirect squashes the word fetched on the old path
    assign clear = advance && (excEnter || excReturn);

    // Memory wait, seen by the pipeline controller
    assign busy = !iReady;

    // CP0 raises entry and return from separate, exclusive events
    singleRedirect: assert final (!(excEnter && excReturn))
        else $error("Exception entry and ERET requested in the same cycle");

endmodule

//--- hdl/FetchStage.sv
// Fetch stage with the instruction memory address, program counter and F/D pipeline register
`timescale 1ns/1ps

module FetchStage
    import mipsIsaPkg::*;
    import mipsMemPkg::*;
#(
    parameter logic [31:0] bootAddress = defaultBootAddress,
    parameter logic [31:0] excEntry    = defaultExcEntry,
    parameter logic [31:0] imStart     = defaultImStart,
    parameter logic [31:0] imEnd       = defaultImEnd
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        enPC,
    input  logic        stall,
    input  logic        clear,
    input  logic [31:0] iRData,
    input  instrClass   iClass,
    input  logic        branchTaken,
    input  logic [15:0] imm16,
    input  logic [25:0] jTarget,
    input  logic [31:0] jumpReg,
    input  logic        excEnter,
    input  logic        excReturn,
    input  logic [31:0] epc,
    output logic [31:0] iAddr,
    output logic [31:0] pcF,
    output logic [31:0] codeD,
    output logic [31:0] pcD,
    output logic        bdD,
    output excCode      excD,
    output logic        fetchValid
);

    logic   bdF;
    excCode excF;

    ProgramCounter #(
        .bootAddress(bootAddress),
        .excEntry   (excEntry),
        .imStart    (imStart),
        .imEnd      (imEnd)
    ) programCounter (
        .clk        (clk),
        .reset      (reset),
        .en         (enPC),
        .iClass     (iClass),
        .branchTaken(branchTaken),
        .imm16      (imm16),
        .jTarget    (jTarget),
        .jumpReg    (jumpReg),
        .excEnter   (excEnter),
        .excReturn  (excReturn),
        .epc        (epc),
        .pc         (pcF),
        .bd         (bdF),
        .exc        (excF)
    );

    assign iAddr = pcF;

    // F/D register, stall holds everything and clear only acts on an advancing edge
    always_ff @(posedge clk) begin
        if (reset) begin
            codeD      <= '0;
            pcD        <= '0;
            bdD        <= 1'b0;
            excD       <= excNone;
            fetchValid <= 1'b0;
        end else if (!stall) begin
            if (clear) begin
                codeD      <= '0;
                pcD        <= '0;
                bdD        <= 1'b0;
                excD       <= excNone;
                fetchValid <= 1'b0;
            end else begin
                codeD      <= iRData;
                pcD        <= pcF;
                bdD        <= bdF;
                excD       <= excF;
                fetchValid <= 1'b1;
            end
        end
    end

    addrHeldOnStall: assert property (@(posedge clk) disable iff (reset) stall |=> $stable(iAddr))
        else $error("Instruction address moved during a stalled cycle");

endmodule

//--- hdl/FetchUnit.sv
// Top level of the MIPS32 fetch front end, wiring control, fetch stage and branch decoder
`timescale 1ns/1ps

module FetchUnit
    import mipsIsaPkg::*;
    import mipsMemPkg::*;
#(
    parameter logic [31:0] bootAddress = defaultBootAddress,
    parameter logic [31:0] excEntry    = defaultExcEntry,
    parameter logic [31:0] imStart     = defaultImStart,
    parameter logic [31:0] imEnd       = defaultImEnd
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] iRData,
    input  logic        iReady,
    input  logic [31:0] rsValue,
    input  logic [31:0] rtValue,
    input  logic        stallIn,
    input  logic        excEnter,
    input  logic        excReturn,
    input  logic [31:0] epc,
    output logic [31:0] iAddr,
    output logic [4:0]  rsIndex,
    output logic [4:0]  rtIndex,
    output logic [31:0] codeD,
    output logic [31:0] pcD,
    output logic        bdD,
    output excCode      excD,
    output logic        fetchValid,
    output logic [31:0] pcF
);

    logic        enPC;
    logic        stall;
    logic        clear;
    instrClass   iClass;
    logic        branchTaken;
    logic [15:0] imm16;
    logic [25:0] jTarget;
    logic [31:0] jumpReg;

    FetchControl fetchControl (
        .iReady   (iReady),
        .stallIn  (stallIn),
        .excEnter (excEnter),
        .excReturn(excReturn),
        .enPC     (enPC),
        .stall    (stall),
        .clear    (clear),
        .busy     ()
    );

    FetchStage #(
        .bootAddress(bootAddress),
        .excEntry   (excEntry),
        .imStart    (imStart),
        .imEnd      (imEnd)
    ) fetchStage (
        .clk        (clk),
        .reset      (reset),
        .enPC       (enPC),
        .stall      (stall),
        .clear      (clear),
        .iRData     (iRData),
        .iClass     (iClass),
        .branchTaken(branchTaken),
        .imm16      (imm16),
        .jTarget    (jTarget),
        .jumpReg    (jumpReg),
        .excEnter   (excEnter),
        .excReturn  (excReturn),
        .epc        (epc),
        .iAddr      (iAddr),
        .pcF        (pcF),
        .codeD      (codeD),
        .pcD        (pcD),
        .bdD        (bdD),
        .excD       (excD),
        .fetchValid (fetchValid)
    );

    // Decodes the D word and feeds the redirect back to the PC
    BranchDecoder branchDecoder (
        .codeD      (codeD),
        .fetchValid (fetchValid),
        .rsValue    (rsValue),
        .rtValue    (rtValue),
        .iClass     (iClass),
        .branchTaken(branchTaken),
        .imm16      (imm16),
        .jTarget    (jTarget),
        .jumpReg    (jumpReg),
        .rsIndex    (rsIndex),
        .rtIndex    (rtIndex)
    );

endmodule

//--- testbench/FetchChecker.sv
// Scoreboard for the fetch unit testbench, compares each valid D-stage record with the trace
`timescale 1ns/1ps

module FetchChecker (
    input  logic        clk,
    input  logic        reset,
    input  logic        iReady,
    input  logic        stallIn,
    input  logic        excEnter,
    input  logic        excReturn,
    input  logic [31:0] iAddr,
    input  logic [31:0] pcF,
    input  logic [31:0] codeD,
    input  logic [31:0] pcD,
    input  logic        bdD,
    input  logic [4:0]  excD,
    input  logic        fetchValid,
    output int          recordCount,
    output int          checkedCount,
    output int          errorCount
);

    logic [31:0] expCode [0:63];
    logic [31:0] expPc   [0:63];
    logic        expBd   [0:63];
    logic [4:0]  expExc  [0:63];
    int          expCount = 0;

    logic        loaded;
    logic        active;
    logic [31:0] lastAddr;
    logic [31:0] lastPcF;
    logic [70:0] lastRecord;

    initial begin
        recordCount  = 0;
        checkedCount = 0;
        errorCount   = 0;
    end

    task automatic addExpected(input logic [31:0] code, input logic [31:0] pc,
                               input logic bd, input logic [4:0] exc);
        expCode[expCount] = code;
        expPc[expCount]   = pc;
        expBd[expCount]   = bd;
        expExc[expCount]  = exc;
        expCount++;
    endtask

    task automatic reportField(input string field, input logic [31:0] got,
                               input logic [31:0] want);
        $display("** Error at %0t ns: record %0d %s is %h, expected %h",
                 $time, checkedCount, field, got, want);
        errorCount++;
    endtask

    // Inputs are stable at the rising edge, so this predicts what the F/D register takes
    always @(posedge clk) begin
        if (reset) begin
            loaded      <= 1'b0;
            active      <= 1'b0;
            recordCount <= 0;
        end else begin
            loaded <= iReady && !stallIn;
            active <= 1'b1;
            // A pending redirect turns the load into a bubble
            if (iReady && !stallIn && !excEnter && !excReturn) begin
                recordCount <= recordCount + 1;
            end
        end
    end

    always @(negedge clk) begin
        if (active && !loaded) begin
            if (iAddr !== lastAddr) begin
                reportField("iAddr during stall", iAddr, lastAddr);
            end
            if ({codeD, pcD, bdD, excD, fetchValid} !== lastRecord) begin
                reportField("D record during stall", pcD, lastRecord[38:7]);
            end
        end else if (loaded && fetchValid) begin
            if (checkedCount >= expCount) begin
                $display("Extra record at %0t ns: pc %h arrived after the trace ended",
                         $time, pcD);
                errorCount++;
            end else begin
                if (codeD !== expCode[checkedCount]) begin
                    reportField("codeD", codeD, expCode[checkedCount]);
                end
                if (pcD !== expPc[checkedCount]) begin
                    reportField("pcD", pcD, expPc[checkedCount]);
                end
                // F-stage PC seen just before the loading edge
                if (lastPcF !== expPc[checkedCount]) begin
                    reportField("pcF before load", lastPcF, expPc[checkedCount]);
                end
                if (bdD !== expBd[checkedCount]) begin
                    reportField("bdD", {31'b0, bdD}, {31'b0, expBd[checkedCount]});
                end
                if (excD !== expExc[checkedCount]) begin
                    reportField("excD", {27'b0, excD}, {27'b0, expExc[checkedCount]});
                end
            end
            checkedCount++;
        end
        lastAddr   = iAddr;
        lastPcF    = pcF;
        lastRecord = {codeD, pcD, bdD, excD, fetchValid};
    end

endmodule

//--- testbench/FetchUnitTb.sv
// Testbench top for the fetch unit, models memory, registers and CP0 from the golden trace file
`timescale 1ns/1ps

module FetchUnitTb;

    localparam int          resetCycles = 16;
    localparam int          memWords    = 4096;
    localparam logic [31:0] memBase     = 32'h0000_3000;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] iRData = '0;
    logic        iReady = 1'b0;
    logic [31:0] rsValue = '0;
    logic [31:0] rtValue = '0;
    logic        stallIn = 1'b0;
    logic        excEnter = 1'b0;
    logic        excReturn = 1'b0;
    logic [31:0] epc = '0;
    logic [31:0] iAddr;
    logic [4:0]  rsIndex;
    logic [4:0]  rtIndex;
    logic [31:0] codeD;
    logic [31:0] pcD;
    logic        bdD;
    logic [4:0]  excD;
    logic        fetchValid;
    logic [31:0] pcF;

    logic [31:0] memory [0:memWords-1];
    logic [31:0] regs [0:31];
    int          eventIndex [0:31];
    int          eventType [0:31];
    logic [31:0] eventValue [0:31];
    int          eventCount = 0;
    int          nextEvent = 0;
    int          traceLength = 0;
    int          stallTotal = 0;
    int          stallLeft = 0;
    int          waitLeft = 0;
    int          cycleCount = 0;
    logic        lastAdvance = 1'b1;
    logic        readyNow;
    logic        stallNow;
    logic [31:0] randState = 32'd77451;
    logic        goldenLoaded = 1'b0;
    logic        runAborted = 1'b0;
    int          recordCount;
    int          checkedCount;
    int          errorCount;

    FetchUnit UUT (
        .clk       (clk),
        .reset     (reset),
        .iRData    (iRData),
        .iReady    (iReady),
        .rsValue   (rsValue),
        .rtValue   (rtValue),
        .stallIn   (stallIn),
        .excEnter  (excEnter),
        .excReturn (excReturn),
        .epc       (epc),
        .iAddr     (iAddr),
        .rsIndex   (rsIndex),
        .rtIndex   (rtIndex),
        .codeD     (codeD),
        .pcD       (pcD),
        .bdD       (bdD),
        .excD      (excD),
        .fetchValid(fetchValid),
        .pcF       (pcF)
    );

    FetchChecker fetchChecker (
        .clk         (clk),
        .reset       (reset),
        .iReady      (iReady),
        .stallIn     (stallIn),
        .excEnter    (excEnter),
        .excReturn   (excReturn),
        .iAddr       (iAddr),
        .pcF         (pcF),
        .codeD       (codeD),
        .pcD         (pcD),
        .bdD         (bdD),
        .excD        (excD),
        .fetchValid  (fetchValid),
        .recordCount (recordCount),
        .checkedCount(checkedCount),
        .errorCount  (errorCount)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Misaligned or out-of-window addresses read as zero
    function automatic logic [31:0] readMemory(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - memBase;
        if (addr[1:0] != 2'b00 || addr < memBase || offset >= memWords * 4) begin
            return 32'h0;
        end
        return memory[offset[31:2]];
    endfunction

    task automatic finishRun;
        $display("Records checked: %0d of %0d, errors: %0d", checkedCount, traceLength,
                 errorCount);
        if (errorCount == 0 && !runAborted) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic loadGolden;
        int          fd;
        int          kind;
        int          rc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [8*160-1:0] lineBuf;
        for (int i = 0; i < memWords; i++) begin
            memory[i] = 32'h0;
        end
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'h0;
        end
        fd = $fopen("testbench/fetchGolden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file testbench/fetchGolden.txt");
            runAborted = 1'b1;
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                case (kind)
                    "M": begin
                        rc = $fscanf(fd, "%h %h", a, b);
                        memory[(a - memBase) >> 2] = b;
                    end
                    "R": begin
                        rc = $fscanf(fd, "%d %h", a, b);
                        regs[a[4:0]] = b;
                    end
                    "E": begin
                        rc = $fscanf(fd, "%d %d %h", a, b, c);
                        eventIndex[eventCount] = a;
                        eventType[eventCount]  = b;
                        eventValue[eventCount] = c;
                        if (b == 1) begin
                            stallTotal += c;
                        end
                        eventCount++;
                    end
                    "X": begin
                        rc = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                        fetchChecker.addExpected(a, b, c[0], d[4:0]);
                        traceLength++;
                    end
                    default: rc = $fgets(lineBuf, fd);
                endcase
            end
            $fclose(fd);
            goldenLoaded = 1'b1;
        end
    endtask

    task automatic applyEvent(input int n);
        case (eventType[n])
            1: stallLeft = eventValue[n];
            2: excEnter <= 1'b1;
            default: begin
                excReturn <= 1'b1;
                epc       <= eventValue[n];
            end
        endcase
    endtask

    // Memory, register file and CP0 models, all changing on the falling edge
    always @(negedge clk) begin
        cycleCount++;
        reset <= (cycleCount < resetCycles);
        if (lastAdvance) begin
            excEnter  <= 1'b0;
            excReturn <= 1'b0;
        end
        if (nextEvent < eventCount && recordCount >= eventIndex[nextEvent]) begin
            applyEvent(nextEvent);
            nextEvent++;
        end
        stallNow = (stallLeft > 0);
        if (stallLeft > 0) begin
            stallLeft--;
        end
        // Each new access waits 0 to 2 cycles
        if (lastAdvance) begin
            randState = xorshift(randState);
            waitLeft  = randState % 3;
        end
        readyNow = (waitLeft == 0);
        if (waitLeft > 0) begin
            waitLeft--;
        end
        stallIn     <= stallNow;
        iReady      <= readyNow;
        lastAdvance = readyNow && !stallNow;
        iRData      <= readMemory(iAddr);
        rsValue     <= regs[rsIndex];
        rtValue     <= regs[rtIndex];
    end

    initial begin
        loadGolden();
        if (goldenLoaded) begin
            wait (checkedCount >= traceLength);
            @(posedge clk);
        end
        finishRun();
    end

    // Up to three cycles per record, plus reset and requested stalls
    initial begin
        wait (goldenLoaded);
        repeat (resetCycles + traceLength * 4 + stallTotal) @(posedge clk);
        $display("Timeout: only %0d of %0d expected records arrived", checkedCount, traceLength);
        runAborted = 1'b1;
        finishRun();
    end

endmodule

//--- testbench/fetchGolden.txt
# M address word | R register value | E recordIndex type value (1 stall cycles, 2 exc entry, 3 ERET epc)
# X code pc bd exc, one line per expected D record in order
M 3000 24003000
M 3004 24003004
M 3008 10220004
M 301C 14220008
M 3024 14230002
M 3030 18800002
M 303C 18600008
M 3044 1C800008
M 304C 1C600003
M 305C 10230008
M 3064 08000C40
M 3100 0C000C80
M 3200 00C00008
M 3300 0120F809
M 3400 24003400
M 3404 24003404
M 3408 00E00008
M 3410 01400008
M 3418 0800105F
M 417C 2400417C
M 4180 42000018
R 1 00000005
R 2 00000005
R 3 00000007
R 4 FFFFFFFF
R 6 00003300
R 7 00003502
R 9 00003400
R 10 00007000
E 5 1 3
E 23 1 2
E 27 2 0
E 28 3 00003407
E 32 2 0
E 33 3 00003410
E 36 2 0
E 37 3 00003418
X 24003000 00003000 0 0
X 24003004 00003004 0 0
X 10220004 00003008 0 0
X 00000000 0000300C 1 0
X 14220008 0000301C 0 0
X 00000000 00003020 1 0
X 14230002 00003024 0 0
X 00000000 00003028 1 0
X 18800002 00003030 0 0
X 00000000 00003034 1 0
X 18600008 0000303C 0 0
X 00000000 00003040 1 0
X 1C800008 00003044 0 0
X 00000000 00003048 1 0
X 1C600003 0000304C 0 0
X 00000000 00003050 1 0
X 10230008 0000305C 0 0
X 00000000 00003060 1 0
X 08000C40 00003064 0 0
X 00000000 00003068 1 0
X 0C000C80 00003100 0 0
X 00000000 00003104 1 0
X 00C00008 00003200 0 0
X 00000000 00003204 1 0
X 0120F809 00003300 0 0
X 00000000 00003304 1 0
X 24003400 00003400 0 0
X 42000018 00004180 0 0
X 24003404 00003404 0 0
X 00E00008 00003408 0 0
X 00000000 0000340C 1 0
X 00000000 00003502 0 4
X 42000018 00004180 0 0
X 01400008 00003410 0 0
X 00000000 00003414 1 0
X 00000000 00007000 0 4
X 42000018 00004180 0 0
X 0800105F 00003418 0 0
X 00000000 0000341C 1 0
X 2400417C 0000417C 0 0
X 2400417C 0000417C 0 0
X 2400417C 0000417C 0 0

//--- files.f
hdl/mipsIsaPkg.sv
hdl/mipsMemPkg.sv
hdl/ProgramCounter.sv
hdl/BranchDecoder.sv
hdl/FetchControl.sv
hdl/FetchStage.sv
hdl/FetchUnit.sv
testbench/FetchChecker.sv
testbench/FetchUnitTb.sv

//--- Bender.yml
package:
  name: mips_fetch

sources:
  - hdl/mipsIsaPkg.sv
  - hdl/mipsMemPkg.sv
  - hdl/ProgramCounter.sv
  - hdl/BranchDecoder.sv
  - hdl/FetchControl.sv
  - hdl/FetchStage.sv
  - hdl/FetchUnit.sv
  - target: test
    files:
      - testbench/FetchChecker.sv
      - testbench/FetchUnitTb.sv
